/* Makefile */
SIM      := verilator
TOP      := tb_axis2axi_wr
FILELIST := axis2axi_wr.f
FLAGS    := --binary --timing --assert -Wno-fatal
BUILD    := obj_dir
LOG      := sim.log
PASS_MSG := All tests passed
FAIL_MSG := Some tests failed

SOURCES := $(shell grep -v '^+' $(FILELIST))
BIN     := $(BUILD)/V$(TOP)

.PHONY: all run clean

all: run

$(BIN): $(SOURCES) $(FILELIST)
	$(SIM) $(FLAGS) --top-module $(TOP) --Mdir $(BUILD) -f $(FILELIST)

run: $(BIN)
	./$(BIN) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG) || ! grep -q "$(PASS_MSG)" $(LOG); then \
		echo "Simulation result: FAIL"; exit 1; fi
	@echo "Simulation result: PASS"

clean:
	rm -rf $(BUILD) $(LOG)

/* axis2axi_in/axis2axi_in.sv */
`timescale 1ns/10ps

module axis2axi_in (
   input  logic                             clk_i,
   input  logic                             arst_n_i,
   // Configuration
   input  logic [axis2axi_pkg::ADDR_W-1:0]  cfg_addr_i,
   input  logic                             cfg_valid_i,
   output logic                             cfg_ready_o,
   // Stream input
   input  logic [axis2axi_pkg::DATA_W-1:0]  s_data_i,
   input  logic                             s_valid_i,
   output logic                             s_ready_o,
   // AXI write
   output logic                             awvalid_o,
   output logic [axis2axi_pkg::ADDR_W-1:0]  awaddr_o,
   output logic [axis2axi_pkg::LEN_W-1:0]   awlen_o,
   input  logic                             awready_i,
   output logic                             wvalid_o,
   output logic [axis2axi_pkg::DATA_W-1:0]  wdata_o,
   output logic                             wlast_o,
   input  logic                             wready_i,
   input  logic                             bvalid_i
);

   axis2axi_pkg::wr_state_e state_q;

   logic [axis2axi_pkg::ADDR_W-1:0]  addr_q;
   logic [axis2axi_pkg::LEN_W-1:0]   awlen_q;
   logic [axis2axi_pkg::LEN_W-1:0]   beat_q;
   logic                             wlast_q;
   logic [axis2axi_pkg::LEVEL_W-1:0] fifo_level;
   logic                             fifo_full;
   logic                             fifo_empty;
   logic                             fifo_rd;
   logic                             normal_possible;
   logic                             final_possible;
   logic                             start_burst;
   logic                             w_hs;
   logic [axis2axi_pkg::BURST_W:0]   fill_len;
   logic [axis2axi_pkg::BURST_W:0]   burst_len;
   logic [12:0]                      page_bytes;
   logic [axis2axi_pkg::ADDR_W-1:0]  burst_bytes;

   assign s_ready_o   = !fifo_full;
   assign cfg_ready_o = (state_q == axis2axi_pkg::WAIT_DATA) && fifo_empty;

   assign awvalid_o = (state_q == axis2axi_pkg::START_TRANSFER);
   assign awaddr_o  = addr_q;
   assign awlen_o   = awlen_q;
   assign wvalid_o  = (state_q == axis2axi_pkg::TRANSFER);
   assign wlast_o   = wlast_q;
   assign w_hs      = wvalid_o && wready_i;

   assign normal_possible = (fifo_level >= axis2axi_pkg::BURST_SIZE);
   assign final_possible  = (fifo_level != '0) && !normal_possible && !s_valid_i;
   assign start_burst     = (state_q == axis2axi_pkg::WAIT_DATA)
                            && (normal_possible || final_possible);

   // Popping at burst start puts the first beat on the FIFO output early
   assign fifo_rd = start_burst || (w_hs && !wlast_q);

   always_comb begin
      if (normal_possible) begin
         fill_len = {1'b1, {axis2axi_pkg::BURST_W{1'b0}}};
      end else begin
         fill_len = fifo_level[axis2axi_pkg::BURST_W:0];
      end
   end

   // Clip to the words left in the 4 KB page
   assign page_bytes = 13'h1000 - {1'b0, addr_q[11:0]};
   always_comb begin
      burst_len = fill_len;
      if (fill_len > page_bytes[12:2]) begin
         burst_len = page_bytes[axis2axi_pkg::BURST_W+2:2];
      end
   end

   assign burst_bytes = {{(axis2axi_pkg::ADDR_W-axis2axi_pkg::LEN_W-2){1'b0}}, awlen_q, 2'b00}
                        + 'd4;

   always_ff @(posedge clk_i or negedge arst_n_i) begin
      if (!arst_n_i) begin
         state_q <= axis2axi_pkg::WAIT_DATA;
         awlen_q <= '0;
         beat_q  <= '0;
         wlast_q <= 1'b0;
      end else begin
         case (state_q)
            axis2axi_pkg::WAIT_DATA: begin
               beat_q <= '0;
               if (start_burst) begin
                  awlen_q <= {{(axis2axi_pkg::LEN_W-axis2axi_pkg::BURST_W-1){1'b0}},
                              burst_len - 1'b1};
                  state_q <= axis2axi_pkg::START_TRANSFER;
               end
            end
            axis2axi_pkg::START_TRANSFER: begin
               if (awready_i) begin
                  // Single-beat burst is last from the start
                  wlast_q <= (awlen_q == '0);
                  state_q <= axis2axi_pkg::TRANSFER;
               end
            end
            axis2axi_pkg::TRANSFER: begin
               if (w_hs) begin
                  beat_q  <= beat_q + 1'b1;
                  wlast_q <= !wlast_q && (beat_q + 1'b1 == awlen_q);
                  if (wlast_q) begin
                     state_q <= axis2axi_pkg::WAIT_BRESP;
                  end
               end
            end
            default: begin
               if (bvalid_i) begin
                  state_q <= axis2axi_pkg::WAIT_DATA;
               end
            end
         endcase
      end
   end

   always_ff @(posedge clk_i or negedge arst_n_i) begin
      if (!arst_n_i) begin
         addr_q <= '0;
      end else if (cfg_valid_i && cfg_ready_o) begin
         addr_q <= cfg_addr_i;
      end else if (w_hs && wlast_q) begin
         addr_q <= addr_q + burst_bytes;
      end
   end

   stream_fifo u_fifo (
      .clk_i    (clk_i),
      .arst_n_i (arst_n_i),
      .w_en_i   (s_valid_i && s_ready_o),
      .w_data_i (s_data_i),
      .w_full_o (fifo_full),
      .r_en_i   (fifo_rd),
      .r_data_o (wdata_o),
      .r_empty_o(fifo_empty),
      .level_o  (fifo_level)
   );

   a_awlen_stable: assert property (@(posedge clk_i) disable iff (!arst_n_i)
      awvalid_o && !awready_i |=> awvalid_o && $stable(awlen_o) && $stable(awaddr_o));

   // wlast comes from its own register, so check it against the beat count
   a_wlast_count: assert property (@(posedge clk_i) disable iff (!arst_n_i)
      wlast_o |-> wvalid_o && (beat_q == awlen_o));

endmodule

/* axis2axi_wr.f */
common/axi_pkg.sv
common/axis2axi_pkg.sv
logic/stream_fifo.sv
axis2axi_in/axis2axi_in.sv
logic/axi_write_arbiter.sv
logic/axis2axi_wr.sv
tests/axi_mem_model.sv
tests/tb_axis2axi_wr.sv

/* common/axi_pkg.sv */
package axi_pkg;

   // Burst type, INCR only
   localparam logic [1:0] BURST_INCR = 2'b01;

   // Beat size of 4 bytes
   localparam logic [2:0] SIZE_4B = 3'b010;

   // Normal non-cacheable, modifiable
   localparam logic [3:0] CACHE_MODIFIABLE = 4'b0010;

   // Unprivileged, non-secure, data access
   localparam logic [2:0] PROT_DATA = 3'b010;

   // Write response codes
   typedef enum logic [1:0] {
      OKAY   = 2'b00,
      EXOKAY = 2'b01,
      SLVERR = 2'b10,
      DECERR = 2'b11
   } resp_e;

endpackage

/* common/axis2axi_pkg.sv */
package axis2axi_pkg;

   // AXI side widths
   localparam int ADDR_W = 16;
   localparam int DATA_W = 32;
   localparam int LEN_W  = 8;

   // Burst of 8 beats
   localparam int BURST_W    = 3;
   localparam int BURST_SIZE = 2 ** BURST_W;

   // FIFO of 16 words, level counts 0..16
   localparam int BUFFER_W = 4;
   localparam int LEVEL_W  = 5;

   localparam int N_CHAN = 2;

   // Per-channel burst writer
   typedef enum logic [1:0] {
      WAIT_DATA      = 2'd0,
      START_TRANSFER = 2'd1,
      TRANSFER       = 2'd2,
      WAIT_BRESP     = 2'd3
   } wr_state_e;

   // Shared write port owner
   typedef enum logic [1:0] {
      ARB_IDLE = 2'd0,
      ARB_BUSY = 2'd1,
      ARB_RESP = 2'd2
   } arb_state_e;

endpackage

/* logic/axi_write_arbiter.sv */
`timescale 1ns/10ps

module axi_write_arbiter (
   input  logic                                                      clk_i,
   input  logic                                                      arst_n_i,
   // Channel side
   input  logic [axis2axi_pkg::N_CHAN-1:0]                           ch_awvalid_i,
   input  logic [axis2axi_pkg::N_CHAN-1:0][axis2axi_pkg::ADDR_W-1:0] ch_awaddr_i,
   input  logic [axis2axi_pkg::N_CHAN-1:0][axis2axi_pkg::LEN_W-1:0]  ch_awlen_i,
   output logic [axis2axi_pkg::N_CHAN-1:0]                           ch_awready_o,
   input  logic [axis2axi_pkg::N_CHAN-1:0]                           ch_wvalid_i,
   input  logic [axis2axi_pkg::N_CHAN-1:0][axis2axi_pkg::DATA_W-1:0] ch_wdata_i,
   input  logic [axis2axi_pkg::N_CHAN-1:0]                           ch_wlast_i,
   output logic [axis2axi_pkg::N_CHAN-1:0]                           ch_wready_o,
   output logic [axis2axi_pkg::N_CHAN-1:0]                           ch_bvalid_o,
   // Memory side
   output logic                                                      m_awvalid_o,
   output logic [axis2axi_pkg::ADDR_W-1:0]                           m_awaddr_o,
   output logic [axis2axi_pkg::LEN_W-1:0]                            m_awlen_o,
   input  logic                                                      m_awready_i,
   output logic                                                      m_wvalid_o,
   output logic [axis2axi_pkg::DATA_W-1:0]                           m_wdata_o,
   output logic                                                      m_wlast_o,
   input  logic                                                      m_wready_i,
   input  logic                                                      m_bvalid_i
);

   typedef logic [$clog2(axis2axi_pkg::N_CHAN)-1:0] idx_t;

   axis2axi_pkg::arb_state_e state_q;

   idx_t grant_q;
   idx_t last_q;
   idx_t sel;
   idx_t cur;
   logic any_req;

   assign any_req = |ch_awvalid_i;

   // Nearest requester after the last winner; walking down lets the closest one win
   always_comb begin
      idx_t cand;
      sel = last_q;
      for (int i = axis2axi_pkg::N_CHAN; i >= 1; i--) begin
         cand = idx_t'((int'(last_q) + i) % axis2axi_pkg::N_CHAN);
         if (ch_awvalid_i[cand]) sel = cand;
      end
   end

   // Grant is combinational while idle
   assign cur = (state_q == axis2axi_pkg::ARB_IDLE) ? sel : grant_q;

   assign m_awvalid_o = (state_q != axis2axi_pkg::ARB_RESP) && ch_awvalid_i[cur];
   assign m_awaddr_o  = ch_awaddr_i[cur];
   assign m_awlen_o   = ch_awlen_i[cur];
   assign m_wvalid_o  = (state_q == axis2axi_pkg::ARB_BUSY) && ch_wvalid_i[cur];
   assign m_wdata_o   = ch_wdata_i[cur];
   assign m_wlast_o   = ch_wlast_i[cur];

   always_comb begin
      ch_awready_o      = '0;
      ch_wready_o       = '0;
      ch_bvalid_o       = '0;
      ch_awready_o[cur] = (state_q != axis2axi_pkg::ARB_RESP) && m_awready_i;
      ch_wready_o[cur]  = (state_q == axis2axi_pkg::ARB_BUSY) && m_wready_i;
      ch_bvalid_o[cur]  = (state_q == axis2axi_pkg::ARB_RESP) && m_bvalid_i;
   end

   always_ff @(posedge clk_i or negedge arst_n_i) begin
      if (!arst_n_i) begin
         state_q <= axis2axi_pkg::ARB_IDLE;
         grant_q <= '0;
         last_q  <= '0;
      end else begin
         case (state_q)
            axis2axi_pkg::ARB_IDLE: begin
               if (any_req) begin
                  grant_q <= sel;
                  last_q  <= sel;
                  state_q <= axis2axi_pkg::ARB_BUSY;
               end
            end
            axis2axi_pkg::ARB_BUSY: begin
               if (m_wvalid_o && m_wready_i && m_wlast_o) state_q <= axis2axi_pkg::ARB_RESP;
            end
            default: begin
               if (m_bvalid_i) state_q <= axis2axi_pkg::ARB_IDLE;
            end
         endcase
      end
   end

   a_grant_held: assert property (@(posedge clk_i) disable iff (!arst_n_i)
      m_awvalid_o && m_awready_i |=> ($stable(cur) throughout m_bvalid_i [->1]));

endmodule

/* logic/axis2axi_wr.sv */
`timescale 1ns/10ps

module axis2axi_wr (
   input  logic                                                      clk_i,
   input  logic                                                      arst_n_i,
   // Per-channel configuration and stream
   input  logic [axis2axi_pkg::N_CHAN-1:0][axis2axi_pkg::ADDR_W-1:0] cfg_addr_i,
   input  logic [axis2axi_pkg::N_CHAN-1:0]                           cfg_valid_i,
   output logic [axis2axi_pkg::N_CHAN-1:0]                           cfg_ready_o,
   input  logic [axis2axi_pkg::N_CHAN-1:0][axis2axi_pkg::DATA_W-1:0] s_data_i,
   input  logic [axis2axi_pkg::N_CHAN-1:0]                           s_valid_i,
   output logic [axis2axi_pkg::N_CHAN-1:0]                           s_ready_o,
   // Shared AXI write port
   output logic                                                      m_axi_awvalid_o,
   output logic [axis2axi_pkg::ADDR_W-1:0]                           m_axi_awaddr_o,
   output logic [axis2axi_pkg::LEN_W-1:0]                            m_axi_awlen_o,
   output logic [2:0]                                                m_axi_awsize_o,
   output logic [1:0]                                                m_axi_awburst_o,
   output logic [3:0]                                                m_axi_awcache_o,
   output logic [2:0]                                                m_axi_awprot_o,
   input  logic                                                      m_axi_awready_i,
   output logic                                                      m_axi_wvalid_o,
   output logic [axis2axi_pkg::DATA_W-1:0]                           m_axi_wdata_o,
   output logic [axis2axi_pkg::DATA_W/8-1:0]                         m_axi_wstrb_o,
   output logic                                                      m_axi_wlast_o,
   input  logic                                                      m_axi_wready_i,
   input  logic                                                      m_axi_bvalid_i,
   input  logic [1:0]                                                m_axi_bresp_i,
   output logic                                                      m_axi_bready_o
);

   logic [axis2axi_pkg::N_CHAN-1:0]                           ch_awvalid;
   logic [axis2axi_pkg::N_CHAN-1:0][axis2axi_pkg::ADDR_W-1:0] ch_awaddr;
   logic [axis2axi_pkg::N_CHAN-1:0][axis2axi_pkg::LEN_W-1:0]  ch_awlen;
   logic [axis2axi_pkg::N_CHAN-1:0]                           ch_awready;
   logic [axis2axi_pkg::N_CHAN-1:0]                           ch_wvalid;
   logic [axis2axi_pkg::N_CHAN-1:0][axis2axi_pkg::DATA_W-1:0] ch_wdata;
   logic [axis2axi_pkg::N_CHAN-1:0]                           ch_wlast;
   logic [axis2axi_pkg::N_CHAN-1:0]                           ch_wready;
   logic [axis2axi_pkg::N_CHAN-1:0]                           ch_bvalid;

   // Full-word INCR writes, responses always accepted
   assign m_axi_awsize_o  = axi_pkg::SIZE_4B;
   assign m_axi_awburst_o = axi_pkg::BURST_INCR;
   assign m_axi_awcache_o = axi_pkg::CACHE_MODIFIABLE;
   assign m_axi_awprot_o  = axi_pkg::PROT_DATA;
   assign m_axi_wstrb_o   = '1;
   assign m_axi_bready_o  = 1'b1;

   axis2axi_in u_in0 (
      .clk_i(clk_i), .arst_n_i(arst_n_i),
      .cfg_addr_i(cfg_addr_i[0]), .cfg_valid_i(cfg_valid_i[0]), .cfg_ready_o(cfg_ready_o[0]),
      .s_data_i(s_data_i[0]), .s_valid_i(s_valid_i[0]), .s_ready_o(s_ready_o[0]),
      .awvalid_o(ch_awvalid[0]), .awaddr_o(ch_awaddr[0]), .awlen_o(ch_awlen[0]),
      .awready_i(ch_awready[0]), .wvalid_o(ch_wvalid[0]), .wdata_o(ch_wdata[0]),
      .wlast_o(ch_wlast[0]), .wready_i(ch_wready[0]), .bvalid_i(ch_bvalid[0])
   );

   axis2axi_in u_in1 (
      .clk_i(clk_i), .arst_n_i(arst_n_i),
      .cfg_addr_i(cfg_addr_i[1]), .cfg_valid_i(cfg_valid_i[1]), .cfg_ready_o(cfg_ready_o[1]),
      .s_data_i(s_data_i[1]), .s_valid_i(s_valid_i[1]), .s_ready_o(s_ready_o[1]),
      .awvalid_o(ch_awvalid[1]), .awaddr_o(ch_awaddr[1]), .awlen_o(ch_awlen[1]),
      .awready_i(ch_awready[1]), .wvalid_o(ch_wvalid[1]), .wdata_o(ch_wdata[1]),
      .wlast_o(ch_wlast[1]), .wready_i(ch_wready[1]), .bvalid_i(ch_bvalid[1])
   );

   axi_write_arbiter u_arb (
      .clk_i(clk_i), .arst_n_i(arst_n_i),
      .ch_awvalid_i(ch_awvalid), .ch_awaddr_i(ch_awaddr), .ch_awlen_i(ch_awlen),
      .ch_awready_o(ch_awready), .ch_wvalid_i(ch_wvalid), .ch_wdata_i(ch_wdata),
      .ch_wlast_i(ch_wlast), .ch_wready_o(ch_wready), .ch_bvalid_o(ch_bvalid),
      .m_awvalid_o(m_axi_awvalid_o), .m_awaddr_o(m_axi_awaddr_o), .m_awlen_o(m_axi_awlen_o),
      .m_awready_i(m_axi_awready_i), .m_wvalid_o(m_axi_wvalid_o), .m_wdata_o(m_axi_wdata_o),
      .m_wlast_o(m_axi_wlast_o), .m_wready_i(m_axi_wready_i), .m_bvalid_i(m_axi_bvalid_i)
   );

   // Writers ignore the response code, so an error here would go unnoticed
   a_resp_okay: assert property (@(posedge clk_i) disable iff (!arst_n_i)
      m_axi_bvalid_i |-> (m_axi_bresp_i == axi_pkg::OKAY));

endmodule

/* logic/stream_fifo.sv */
`timescale 1ns/10ps

module stream_fifo (
   input  logic                             clk_i,
   input  logic                             arst_n_i,
   input  logic                             w_en_i,
   input  logic [axis2axi_pkg::DATA_W-1:0]  w_data_i,
   output logic                             w_full_o,
   input  logic                             r_en_i,
   output logic [axis2axi_pkg::DATA_W-1:0]  r_data_o,
   output logic                             r_empty_o,
   output logic [axis2axi_pkg::LEVEL_W-1:0] level_o
);

   logic [axis2axi_pkg::DATA_W-1:0]   mem [2**axis2axi_pkg::BUFFER_W];
   logic [axis2axi_pkg::BUFFER_W-1:0] w_ptr_q;
   logic [axis2axi_pkg::BUFFER_W-1:0] r_ptr_q;
   logic [axis2axi_pkg::LEVEL_W-1:0]  level_q;
   logic                              push;
   logic                              pop;

   // Level MSB set means all 16 slots taken
   assign w_full_o  = level_q[axis2axi_pkg::BUFFER_W];
   assign r_empty_o = (level_q == '0);
   assign level_o   = level_q;

   assign push = w_en_i && !w_full_o;
   assign pop  = r_en_i && !r_empty_o;

   always_ff @(posedge clk_i) begin
      if (push) begin
         mem[w_ptr_q] <= w_data_i;
      end
   end

   // Read data shows up one cycle after the pop
   always_ff @(posedge clk_i) begin
      if (pop) begin
         r_data_o <= mem[r_ptr_q];
      end
   end

   always_ff @(posedge clk_i or negedge arst_n_i) begin
      if (!arst_n_i) begin
         w_ptr_q <= '0;
         r_ptr_q <= '0;
         level_q <= '0;
      end else begin
         if (push) w_ptr_q <= w_ptr_q + 1'b1;
         if (pop) r_ptr_q <= r_ptr_q + 1'b1;
         case ({push, pop})
            2'b10:   level_q <= level_q + 1'b1;
            2'b01:   level_q <= level_q - 1'b1;
            default: level_q <= level_q;
         endcase
      end
   end

   // The writer must gate its own push and pop
   a_no_push_full: assert property (@(posedge clk_i) disable iff (!arst_n_i)
      w_en_i |-> !w_full_o);
   a_no_pop_empty: assert property (@(posedge clk_i) disable iff (!arst_n_i)
      r_en_i |-> !r_empty_o);

endmodule

/* tests/axi_mem_model.sv */
`timescale 1ns/10ps

module axi_mem_model (
   input  logic                            clk_i,
   input  logic                            arst_n_i,
   input  logic                            awvalid_i,
   input  logic [axis2axi_pkg::ADDR_W-1:0] awaddr_i,
   output logic                            awready_o,
   input  logic                            wvalid_i,
   input  logic [axis2axi_pkg::DATA_W-1:0] wdata_i,
   input  logic                            wlast_i,
   output logic                            wready_o,
   output logic                            bvalid_o,
   output logic [1:0]                      bresp_o,
   input  logic                            bready_i
);

   logic [axis2axi_pkg::DATA_W-1:0] mem [2**(axis2axi_pkg::ADDR_W-2)];
   logic [31:0]                     rnd_q;
   logic                            busy_q;
   logic                            bvalid_q;
   logic [axis2axi_pkg::ADDR_W-1:0] addr_q;

   function automatic logic [31:0] lcg_step(input logic [31:0] s);
      return s * 32'd1664525 + 32'd1013904223;
   endfunction

   // Ready about three cycles in four, taken from the upper LCG bits
   assign awready_o = !busy_q && !bvalid_q && (rnd_q[31] || rnd_q[30]);
   assign wready_o  = busy_q && (rnd_q[29] || rnd_q[28]);
   assign bvalid_o  = bvalid_q;
   assign bresp_o   = axi_pkg::OKAY;

   always_ff @(posedge clk_i or negedge arst_n_i) begin
      if (!arst_n_i) begin
         rnd_q    <= 32'hf429;
         busy_q   <= 1'b0;
         bvalid_q <= 1'b0;
         addr_q   <= '0;
      end else begin
         rnd_q <= lcg_step(rnd_q);
         if (awvalid_i && awready_o) begin
            busy_q <= 1'b1;
            addr_q <= awaddr_i;
         end
         if (wvalid_i && wready_o) begin
            addr_q <= addr_q + 'd4;
            if (wlast_i) begin
               busy_q   <= 1'b0;
               bvalid_q <= 1'b1;
            end
         end
         if (bvalid_q && bready_i) bvalid_q <= 1'b0;
      end
   end

   always_ff @(posedge clk_i) begin
      if (wvalid_i && wready_o) mem[addr_q[axis2axi_pkg::ADDR_W-1:2]] <= wdata_i;
   end

endmodule

/* tests/axis2axi_wr_testdata.mem */
// flags channel base_address word_count first_word, all hex
// flags bit 0 puts gaps in the stream, bit 1 runs the record alongside the next one
0 0 0100 14 a0000000
0 1 0ff8 08 b0000000
0 0 1ff0 0b c0000000
2 0 2400 18 d0000000
0 1 2ff4 18 e0000000
1 0 4000 25 f0000000
1 1 4fe4 13 11110000
3 0 5800 30 22220000
1 1 6000 30 33330000
// End marker, a word count of zero
0 0 0000 00 00000000

/* tests/tb_axis2axi_wr.sv */
`timescale 1ns/10ps

module tb_axis2axi_wr;

   localparam int MAX_REC   = 16;
   localparam int REC_WORDS = 5;

   logic                                                      clk;
   logic                                                      arst_n;
   logic [axis2axi_pkg::N_CHAN-1:0][axis2axi_pkg::ADDR_W-1:0] cfg_addr;
   logic [axis2axi_pkg::N_CHAN-1:0]                           cfg_valid;
   logic [axis2axi_pkg::N_CHAN-1:0]                           cfg_ready;
   logic [axis2axi_pkg::N_CHAN-1:0][axis2axi_pkg::DATA_W-1:0] s_data;
   logic [axis2axi_pkg::N_CHAN-1:0]                           s_valid;
   logic [axis2axi_pkg::N_CHAN-1:0]                           s_ready;
   logic                              m_axi_awvalid;
   logic [axis2axi_pkg::ADDR_W-1:0]   m_axi_awaddr;
   logic [axis2axi_pkg::LEN_W-1:0]    m_axi_awlen;
   logic [2:0]                        m_axi_awsize;
   logic [1:0]                        m_axi_awburst;
   logic [3:0]                        m_axi_awcache;
   logic [2:0]                        m_axi_awprot;
   logic                              m_axi_awready;
   logic                              m_axi_wvalid;
   logic [axis2axi_pkg::DATA_W-1:0]   m_axi_wdata;
   logic [axis2axi_pkg::DATA_W/8-1:0] m_axi_wstrb;
   logic                              m_axi_wlast;
   logic                              m_axi_wready;
   logic                              m_axi_bvalid;
   logic [1:0]                        m_axi_bresp;
   logic                              m_axi_bready;

   logic [31:0] tdata [MAX_REC*REC_WORDS];
   int          n_rec;
   int          rec_flags [MAX_REC];
   int          rec_chan  [MAX_REC];
   int          rec_base  [MAX_REC];
   int          rec_count [MAX_REC];
   logic [31:0] rec_first [MAX_REC];
   // Next expected burst address, and words not yet covered by an AW
   int          rec_next  [MAX_REC];
   int          rec_left  [MAX_REC];
   // Burst currently on the W channel
   int          w_rec;
   int          w_addr;
   int          w_beat;
   int          w_len;
   logic [31:0] rand_state = 32'hf429;
   int          cycles = 0;
   int          cycle_limit = 0;

   axis2axi_wr u_axis2axi_wr (
      .clk_i(clk), .arst_n_i(arst_n),
      .cfg_addr_i(cfg_addr), .cfg_valid_i(cfg_valid), .cfg_ready_o(cfg_ready),
      .s_data_i(s_data), .s_valid_i(s_valid), .s_ready_o(s_ready),
      .m_axi_awvalid_o(m_axi_awvalid), .m_axi_awaddr_o(m_axi_awaddr),
      .m_axi_awlen_o(m_axi_awlen), .m_axi_awsize_o(m_axi_awsize),
      .m_axi_awburst_o(m_axi_awburst), .m_axi_awcache_o(m_axi_awcache),
      .m_axi_awprot_o(m_axi_awprot), .m_axi_awready_i(m_axi_awready),
      .m_axi_wvalid_o(m_axi_wvalid), .m_axi_wdata_o(m_axi_wdata), .m_axi_wstrb_o(m_axi_wstrb),
      .m_axi_wlast_o(m_axi_wlast), .m_axi_wready_i(m_axi_wready),
      .m_axi_bvalid_i(m_axi_bvalid), .m_axi_bresp_i(m_axi_bresp), .m_axi_bready_o(m_axi_bready)
   );

   axi_mem_model u_mem (
      .clk_i(clk), .arst_n_i(arst_n),
      .awvalid_i(m_axi_awvalid), .awaddr_i(m_axi_awaddr), .awready_o(m_axi_awready),
      .wvalid_i(m_axi_wvalid), .wdata_i(m_axi_wdata), .wlast_i(m_axi_wlast),
      .wready_o(m_axi_wready), .bvalid_o(m_axi_bvalid), .bresp_o(m_axi_bresp),
      .bready_i(m_axi_bready)
   );

   initial begin
      clk = 1'b0;
      forever #4 clk = ~clk;
   end

   function automatic logic [31:0] next_random();
      rand_state = rand_state * 32'd1664525 + 32'd1013904223;
      return rand_state;
   endfunction

   task automatic check_value(input logic [31:0] got, input logic [31:0] exp, input string what);
      if (got !== exp) begin
         $display("** Error at %0t ns: %s, got %h, expected %h", $time, what, got, exp);
         $display("Some tests failed");
         $fatal(1, "Stopping at the first error");
      end
   endtask

   // Burst length must be min(8, words left, words left in the 4 KB page)
   task automatic follow_aw();
      int r;
      int i;
      int len;
      int page_left;
      int limit_len;
      r = -1;
      for (i = 0; i < n_rec; i++) begin
         if (m_axi_awaddr >= rec_base[i] && m_axi_awaddr < rec_base[i] + 4 * rec_count[i]) r = i;
      end
      check_value(r >= 0, 1, "AW address inside a test region");
      len       = int'(m_axi_awlen) + 1;
      page_left = (4096 - int'(m_axi_awaddr) % 4096) / 4;
      limit_len = axis2axi_pkg::BURST_SIZE;
      if (rec_left[r] < limit_len) limit_len = rec_left[r];
      if (page_left < limit_len) limit_len = page_left;
      check_value(m_axi_awaddr, rec_next[r], "burst start address");
      check_value(m_axi_awsize, axi_pkg::SIZE_4B, "AW size");
      check_value(m_axi_awburst, axi_pkg::BURST_INCR, "AW burst type");
      check_value(m_axi_awcache, axi_pkg::CACHE_MODIFIABLE, "AW cache");
      check_value(m_axi_awprot, axi_pkg::PROT_DATA, "AW prot");
      if (rec_flags[r] % 2 == 1) begin
         // Stream gaps make the flush point unpredictable
         check_value(len <= limit_len, 1, "burst length within its limit");
      end else begin
         check_value(len, limit_len, "burst length");
      end
      check_value((int'(m_axi_awaddr) + 4 * len - 1) / 4096, int'(m_axi_awaddr) / 4096,
                  "burst stays in its 4 KB page");
      rec_next[r] += 4 * len;
      rec_left[r] -= len;
      w_rec  = r;
      w_addr = int'(m_axi_awaddr);
      w_beat = 0;
      w_len  = len;
   endtask

   // A beat from the other channel would carry data outside this record's range
   task automatic verify_beat();
      check_value(m_axi_wdata, rec_first[w_rec] + (w_addr - rec_base[w_rec]) / 4,
                  "W data of the granted channel");
      check_value(m_axi_wlast, w_beat == w_len - 1, "wlast on the last beat");
      check_value(m_axi_wstrb, 4'hf, "write strobes");
      w_addr += 4;
      w_beat++;
   endtask

   always @(negedge clk) begin
      if (arst_n) begin
         if (m_axi_awvalid && m_axi_awready) follow_aw();
         if (m_axi_wvalid && m_axi_wready) verify_beat();
         if (m_axi_bvalid && m_axi_bready) check_value(m_axi_bresp, axi_pkg::OKAY, "B response");
      end
   end

   always @(posedge clk) begin
      cycles++;
      if (cycle_limit > 0 && cycles > cycle_limit) begin
         $display("Timeout: the run did not finish within %0d cycles", cycle_limit);
         $display("Some tests failed");
         $fatal(1, "Stopping on timeout");
      end
   end

   task automatic run_record(input int r);
      int ch;
      int sent;
      int i;
      ch = rec_chan[r];
      @(posedge clk);
      cfg_addr[ch]  <= rec_base[r][axis2axi_pkg::ADDR_W-1:0];
      cfg_valid[ch] <= 1'b1;
      @(negedge clk);
      while (!cfg_ready[ch]) @(negedge clk);
      @(posedge clk);
      cfg_valid[ch] <= 1'b0;
      sent = 0;
      while (sent < rec_count[r]) begin
         // About one gap in four when gaps are enabled
         if (rec_flags[r] % 2 == 1 && next_random() < 32'h4000_0000) begin
            s_valid[ch] <= 1'b0;
            @(posedge clk);
         end else begin
            s_valid[ch] <= 1'b1;
            s_data[ch]  <= rec_first[r] + sent;
            @(negedge clk);
            while (!s_ready[ch]) @(negedge clk);
            @(posedge clk);
            sent++;
         end
      end
      s_valid[ch] <= 1'b0;
      // Idle again once the FIFO has drained and the last B has come back
      @(negedge clk);
      while (!cfg_ready[ch]) @(negedge clk);
      check_value(rec_left[r], 0, "words left without a burst");
      for (i = 0; i < rec_count[r]; i++) begin
         check_value(u_mem.mem[rec_base[r] / 4 + i], rec_first[r] + i, "memory word");
      end
   endtask

   initial begin
      int r;
      int total;
      arst_n    = 1'b0;
      cfg_addr  = '0;
      cfg_valid = '0;
      s_data    = '0;
      s_valid   = '0;
      for (r = 0; r < MAX_REC * REC_WORDS; r++) tdata[r] = '0;
      $readmemh("tests/axis2axi_wr_testdata.mem", tdata);
      n_rec = 0;
      total = 0;
      while (n_rec < MAX_REC && tdata[n_rec * REC_WORDS + 3] != 0) begin
         rec_flags[n_rec] = int'(tdata[n_rec * REC_WORDS]);
         rec_chan[n_rec]  = int'(tdata[n_rec * REC_WORDS + 1]);
         rec_base[n_rec]  = int'(tdata[n_rec * REC_WORDS + 2]);
         rec_count[n_rec] = int'(tdata[n_rec * REC_WORDS + 3]);
         rec_first[n_rec] = tdata[n_rec * REC_WORDS + 4];
         rec_next[n_rec]  = rec_base[n_rec];
         rec_left[n_rec]  = rec_count[n_rec];
         total += rec_count[n_rec];
         n_rec++;
      end
      cycle_limit = 20 * total + 2000;
      check_value(n_rec > 0, 1, "test records read");

      repeat (5) @(posedge clk);
      arst_n <= 1'b1;
      @(negedge clk);
      check_value(cfg_ready, 2'b11, "cfg_ready after reset");
      check_value(s_ready, 2'b11, "s_ready after reset");
      check_value(m_axi_awvalid, 1'b0, "awvalid after reset");
      check_value(m_axi_wvalid, 1'b0, "wvalid after reset");
      check_value(m_axi_bready, 1'b1, "bready after reset");

      r = 0;
      while (r < n_rec) begin
         if (rec_flags[r] / 2 % 2 == 1 && r + 1 < n_rec) begin
            fork
               run_record(r);
               run_record(r + 1);
            join
            r += 2;
         end else begin
            run_record(r);
            r++;
         end
      end
      repeat (10) @(posedge clk);
      $display("All tests passed");
      $finish;
   end

endmodule
